//--- Bender.yml
package:
  name: qla_board

sources:
  - files:
      - qla_pkg.sv
      - reg_bus_decode.sv
      - motor_channel.sv
      - dac_ctrl.sv
      - quad_encoder.sv
      - qla_board.sv
  - target: test
    files:
      - qla_board_asserts.sv
      - tb_qla_board.sv

//--- dac_ctrl.sv
`timescale 1ns/1ps

module dac_ctrl import qla_pkg::*; #(
    parameter int SCLK_HALF = 2                      // sysclk cycles per sclk phase
) (
    input  logic                               sysclk,
    input  logic                               arst_n,
    input  logic                               dac_req_set,
    input  logic [NUM_CHAN-1:0][CMD_WIDTH-1:0] cur_cmd,
    output logic                               dac_sclk,
    output logic                               dac_mosi,
    output logic                               dac_csel
);

    localparam int TICK_W  = $clog2(2 * SCLK_HALF + 1);
    localparam int BIT_W   = $clog2(DAC_FRAME_BITS);
    localparam int CHAN_W  = $clog2(NUM_CHAN);
    localparam int SHIFT_W = NUM_CHAN * DAC_FRAME_BITS;

    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_SHIFT,                                   // csel low, clocking bits
        DAC_GAP                                      // csel high between frames
    } dac_state_e;

    dac_state_e         state;
    logic               req_pend;                    // update asked for
    logic               start;
    logic [TICK_W-1:0]  tick_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    logic [CHAN_W-1:0]  chan_cnt;
    logic [SHIFT_W-1:0] shift_q;                     // all four frames, channel 1 on top
    logic [SHIFT_W-1:0] load_val;

    function automatic logic [DAC_FRAME_BITS-1:0] dac_frame(
        input logic [CHAN_W-1:0]    idx,
        input logic [CMD_WIDTH-1:0] data
    );
        return {DAC_CMD_WRITE_UPDATE, 4'(idx), data};
    endfunction

    // snapshot of every command at update start
    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            load_val[(NUM_CHAN-1-i)*DAC_FRAME_BITS +: DAC_FRAME_BITS] =
                dac_frame(CHAN_W'(i), cur_cmd[i]);
        end
    end

    assign start    = (state == DAC_IDLE) && req_pend;
    assign dac_mosi = shift_q[SHIFT_W-1];            // msb first

    // new request wins over the clear so nothing is lost
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            req_pend <= 1'b0;
        end else if (dac_req_set) begin
            req_pend <= 1'b1;
        end else if (start) begin
            req_pend <= 1'b0;
        end
    end

    // ------------------------------
    // framing FSM
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DAC_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            chan_cnt <= '0;
            shift_q  <= '0;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (start) begin
                        shift_q  <= load_val;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        chan_cnt <= '0;
                        dac_csel <= 1'b0;
                        state    <= DAC_SHIFT;
                    end
                end
                DAC_SHIFT: begin
                    if (tick_cnt == TICK_W'(SCLK_HALF - 1)) begin
                        tick_cnt <= '0;
                        dac_sclk <= ~dac_sclk;
                        if (dac_sclk) begin                      // falling sclk
                            shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_W'(DAC_FRAME_BITS - 1)) begin
                                bit_cnt  <= '0;
                                dac_csel <= 1'b1;                // frame done
                                state    <= DAC_GAP;
                            end
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                DAC_GAP: begin
                    if (tick_cnt == TICK_W'(2 * SCLK_HALF - 1)) begin
                        tick_cnt <= '0;
                        if (chan_cnt == CHAN_W'(NUM_CHAN - 1)) begin
                            state <= DAC_IDLE;                   // update complete
                        end else begin
                            chan_cnt <= chan_cnt + 1'b1;
                            dac_csel <= 1'b0;
                            state    <= DAC_SHIFT;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

endmodule

//--- motor_channel.sv
`timescale 1ns/1ps

module motor_channel import qla_pkg::*; (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic                 cmd_wen,          // write to OFF_DAC_CTRL
    input  logic                 ctrl_wen,         // write to OFF_MOTOR_CTRL
    input  logic [31:0]          wdata,
    input  logic                 amp_fault,        // low means fault
    output logic [CMD_WIDTH-1:0] cur_cmd,
    output chan_status_t         status,
    output logic                 amp_disable_pin
);

    logic         fault_q;        // sampled fault pin
    chan_status_t status_nxt;

    // commanded current register
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
        end else if (cmd_wen) begin
            cur_cmd <= wdata[CMD_WIDTH-1:0];
        end
    end

    // ------------------------------
    // enable and safety latch
    // ------------------------------
    always_comb begin
        status_nxt = status;
        if (ctrl_wen) begin
            status_nxt.amp_enable = wdata[0];
            if (wdata[0]) begin                       // enabling write re-arms
                status_nxt.safety_disable = 1'b0;
                status_nxt.fault_seen     = 1'b0;
            end
        end else if (status.amp_enable && !fault_q) begin
            status_nxt.safety_disable = 1'b1;        // trip while running
            status_nxt.fault_seen     = 1'b1;
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            fault_q         <= 1'b1;                  // idle level is no fault
            status          <= '0;
            amp_disable_pin <= 1'b1;                  // amp held off
        end else begin
            fault_q         <= amp_fault;
            status          <= status_nxt;
            // pin tracks the register state it is computed with
            amp_disable_pin <= ~status_nxt.amp_enable | status_nxt.safety_disable;
        end
    end

endmodule

//--- qla_board.f
qla_pkg.sv
reg_bus_decode.sv
motor_channel.sv
dac_ctrl.sv
quad_encoder.sv
qla_board.sv
qla_board_asserts.sv
tb_qla_board.sv

//--- qla_board.sv
`timescale 1ns/1ps

module qla_board import qla_pkg::*; #(
    parameter int SCLK_HALF = 2                       // dac bit clock half period
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  reg_wr_t             reg_wr,
    input  reg_addr_t           reg_raddr,
    output logic [31:0]         reg_rdata,
    input  logic [NUM_CHAN-1:0] enc_a,
    input  logic [NUM_CHAN-1:0] enc_b,
    input  logic [NUM_CHAN-1:0] amp_fault,          // active low
    output logic [NUM_CHAN-1:0] amp_disable_pin,
    output logic                dac_sclk,
    output logic                dac_mosi,
    output logic                dac_csel
);

    chan_wr_t                           chan_wr;      // per-axis strobes
    logic                               dac_req_set;
    logic [NUM_CHAN-1:0][CMD_WIDTH-1:0] cur_cmd;
    chan_status_t [NUM_CHAN-1:0]        status;
    logic [NUM_CHAN-1:0][ENC_WIDTH-1:0] enc_count;
    logic [NUM_CHAN-1:0][ENC_WIDTH-1:0] enc_preload;

    // ------------------------------
    // address decode and read mux
    // ------------------------------
    reg_bus_decode i_reg_bus_decode (
        .reg_wr      (reg_wr),
        .reg_raddr   (reg_raddr),
        .cur_cmd     (cur_cmd),
        .status      (status),
        .enc_count   (enc_count),
        .enc_preload (enc_preload),
        .chan_wr     (chan_wr),
        .dac_req_set (dac_req_set),
        .reg_rdata   (reg_rdata)
    );

    // one channel per axis, index 0 is channel 1
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        motor_channel i_motor_channel (
            .sysclk          (sysclk),
            .arst_n          (arst_n),
            .cmd_wen         (chan_wr.cmd_wen[i]),
            .ctrl_wen        (chan_wr.ctrl_wen[i]),
            .wdata           (reg_wr.wdata),
            .amp_fault       (amp_fault[i]),
            .cur_cmd         (cur_cmd[i]),
            .status          (status[i]),
            .amp_disable_pin (amp_disable_pin[i])
        );
    end

    // ------------------------------
    // dac and encoders
    // ------------------------------
    dac_ctrl #(
        .SCLK_HALF (SCLK_HALF)
    ) i_dac_ctrl (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .dac_req_set (dac_req_set),
        .cur_cmd     (cur_cmd),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel)
    );

    quad_encoder i_quad_encoder (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .enc_a       (enc_a),
        .enc_b       (enc_b),
        .preload_wen (chan_wr.preload_wen),
        .wdata       (reg_wr.wdata),
        .enc_count   (enc_count),
        .enc_preload (enc_preload)
    );

endmodule

//--- qla_board_asserts.sv
`timescale 1ns/1ps

module qla_board_asserts import qla_pkg::*; (
    input logic                sysclk,
    input logic                arst_n,
    input reg_addr_t           reg_raddr,
    input logic [31:0]         reg_rdata,
    input logic [NUM_CHAN-1:0] amp_disable_pin,
    input logic                dac_sclk,
    input logic                dac_mosi,
    input logic                dac_csel
);

    int unsigned fail_cnt = 0;    // failed checks so far

    // ------------------------------
    // reset levels
    // ------------------------------
    a_reset_levels: assert property (@(posedge sysclk)
        $rose(arst_n) |-> dac_csel && !dac_sclk && (amp_disable_pin == '1))   // at release
    else begin
        fail_cnt++;
        $error("dac or amp outputs not at their reset levels");
    end

    // ------------------------------
    // dac serial framing
    // ------------------------------
    a_sclk_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
        dac_csel |-> !dac_sclk)       // no clocking outside a frame
    else begin
        fail_cnt++;
        $error("dac_sclk high while dac_csel is high");
    end

    // data only moves on the falling sclk edge
    a_mosi_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
        dac_sclk |-> $stable(dac_mosi))
    else begin
        fail_cnt++;
        $error("dac_mosi changed while dac_sclk was high");
    end

    // unmapped channels read as zero
    a_rdata_unmapped: assert property (@(posedge sysclk) disable iff (!arst_n)
        (reg_raddr.chan == 4'd0 || reg_raddr.chan > 4'(NUM_CHAN)) |-> reg_rdata == '0)
    else begin
        fail_cnt++;
        $error("nonzero read data from a channel outside 1 to 4");
    end

endmodule

bind qla_board qla_board_asserts i_qla_board_asserts (.*);

//--- qla_pkg.sv
package qla_pkg;

    // ------------------------------
    // board sizes
    // ------------------------------
    localparam int NUM_CHAN       = 4;    // axes on the board
    localparam int CMD_WIDTH      = 16;   // commanded current
    localparam int ENC_WIDTH      = 24;   // quadrature count
    localparam int DAC_FRAME_BITS = 24;   // one serial dac frame

    // dac command nibble for write and update
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'b0011;

    // ------------------------------
    // address map
    // ------------------------------
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'd0                  // per-axis register space
    } addr_space_e;

    typedef enum logic [3:0] {
        OFF_MOTOR_CTRL = 4'd0,            // amp control and status
        OFF_DAC_CTRL   = 4'd1,            // commanded current
        OFF_ENC_LOAD   = 4'd4,            // encoder preload
        OFF_ENC_DATA   = 4'd5             // encoder count
    } reg_offset_e;

    typedef struct packed {
        logic [3:0] space;                // compared against addr_space_e
        logic [3:0] unused;
        logic [3:0] chan;                 // axes sit at 1 to 4
        logic [3:0] offset;               // compared against reg_offset_e
    } reg_addr_t;

    typedef struct packed {
        reg_addr_t   waddr;
        logic [31:0] wdata;
        logic        wen;                 // register write strobe
        logic        blk_wen;             // block write strobe
    } reg_wr_t;

    // one bit per axis with bit 0 for channel 1
    typedef struct packed {
        logic [NUM_CHAN-1:0] ctrl_wen;
        logic [NUM_CHAN-1:0] cmd_wen;
        logic [NUM_CHAN-1:0] preload_wen;
    } chan_wr_t;

    // amp_enable ends up in bit 0 of the readback
    typedef struct packed {
        logic fault_seen;                 // sticky fault flag
        logic safety_disable;             // latched amp shutdown
        logic amp_enable;                 // host enable
    } chan_status_t;

endpackage

//--- quad_encoder.sv
`timescale 1ns/1ps

module quad_encoder import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               arst_n,
    input  logic [NUM_CHAN-1:0]                enc_a,
    input  logic [NUM_CHAN-1:0]                enc_b,
    input  logic [NUM_CHAN-1:0]                preload_wen,
    input  logic [31:0]                        wdata,
    output logic [NUM_CHAN-1:0][ENC_WIDTH-1:0] enc_count,
    output logic [NUM_CHAN-1:0][ENC_WIDTH-1:0] enc_preload
);

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_enc
        logic [2:0] a_q;       // [1:0] synchronizer, [2] previous state
        logic [2:0] b_q;
        logic       step;      // exactly one input changed
        logic       up;        // A leads B

        // ------------------------------
        // input sync
        // ------------------------------
        always_ff @(posedge sysclk or negedge arst_n) begin
            if (!arst_n) begin
                a_q <= '0;
                b_q <= '0;
            end else begin
                a_q <= {a_q[1:0], enc_a[i]};
                b_q <= {b_q[1:0], enc_b[i]};
            end
        end

        // both changing at once is illegal and drops out here
        assign step = a_q[1] ^ a_q[2] ^ b_q[1] ^ b_q[2];
        assign up   = a_q[1] ^ b_q[2];

        // ------------------------------
        // counter and preload
        // ------------------------------
        always_ff @(posedge sysclk or negedge arst_n) begin
            if (!arst_n) begin
                enc_count[i] <= '0;
            end else if (preload_wen[i]) begin            // preload beats a step
                enc_count[i] <= wdata[ENC_WIDTH-1:0];
            end else if (step) begin
                enc_count[i] <= up ? enc_count[i] + 1'b1  // wraps
                                   : enc_count[i] - 1'b1;
            end
        end

        always_ff @(posedge sysclk or negedge arst_n) begin
            if (!arst_n) begin
                enc_preload[i] <= '0;
            end else if (preload_wen[i]) begin
                enc_preload[i] <= wdata[ENC_WIDTH-1:0];   // kept for readback
            end
        end
    end

endmodule

//--- reg_bus_decode.sv
`timescale 1ns/1ps

module reg_bus_decode import qla_pkg::*; (
    input  reg_wr_t                              reg_wr,
    input  reg_addr_t                            reg_raddr,
    input  logic [NUM_CHAN-1:0][CMD_WIDTH-1:0]   cur_cmd,
    input  chan_status_t [NUM_CHAN-1:0]          status,
    input  logic [NUM_CHAN-1:0][ENC_WIDTH-1:0]   enc_count,
    input  logic [NUM_CHAN-1:0][ENC_WIDTH-1:0]   enc_preload,
    output chan_wr_t                             chan_wr,
    output logic                                 dac_req_set,
    output logic [31:0]                          reg_rdata
);

    localparam int IDX_W = $clog2(NUM_CHAN);

    logic                wr_ok;     // write hits a real axis
    logic [NUM_CHAN-1:0] wr_sel;    // one-hot axis select
    logic                rd_ok;     // read hits a real axis
    logic [IDX_W-1:0]    rd_idx;    // axis index for read mux

    // main space and channel 1..NUM_CHAN
    function automatic logic axis_hit(input reg_addr_t addr);
        return (addr.space == ADDR_MAIN) && (addr.chan >= 4'd1) &&
               (addr.chan <= 4'(NUM_CHAN));
    endfunction

    // ------------------------------
    // write strobes
    // ------------------------------
    assign wr_ok = reg_wr.wen && axis_hit(reg_wr.waddr);

    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            wr_sel[i] = wr_ok && (reg_wr.waddr.chan == 4'(i + 1));
        end
    end

    always_comb begin
        chan_wr.ctrl_wen    = (reg_wr.waddr.offset == OFF_MOTOR_CTRL) ? wr_sel : '0;
        chan_wr.cmd_wen     = (reg_wr.waddr.offset == OFF_DAC_CTRL)   ? wr_sel : '0;
        chan_wr.preload_wen = (reg_wr.waddr.offset == OFF_ENC_LOAD)   ? wr_sel : '0;
    end

    // block write into the dac offset asks for a dac update
    assign dac_req_set = wr_ok && reg_wr.blk_wen && (reg_wr.waddr.offset == OFF_DAC_CTRL);

    // ------------------------------
    // read mux, same cycle
    // ------------------------------
    assign rd_ok  = axis_hit(reg_raddr);
    assign rd_idx = IDX_W'(reg_raddr.chan - 4'd1);   // channel 1 is index 0

    always_comb begin
        reg_rdata = '0;                                // unmapped reads as zero
        if (rd_ok) begin
            case (reg_raddr.offset)
                OFF_MOTOR_CTRL: reg_rdata = {29'd0, status[rd_idx]};
                OFF_DAC_CTRL:   reg_rdata = {{(32-CMD_WIDTH){1'b0}}, cur_cmd[rd_idx]};
                OFF_ENC_LOAD:   reg_rdata = {{(32-ENC_WIDTH){1'b0}}, enc_preload[rd_idx]};
                OFF_ENC_DATA:   reg_rdata = {{(32-ENC_WIDTH){1'b0}}, enc_count[rd_idx]};
                default:        reg_rdata = '0;
            endcase
        end
    end

endmodule

//--- tb_qla_board.sv
`timescale 1ns/1ps

module tb_qla_board import qla_pkg::*; ();

    localparam int SEED        = 96062;
    localparam int HALF_PERIOD = 4;      // 8 ns clock
    localparam int CSEL_LIMIT  = 64;     // cycles to wait for a csel edge
    localparam int BIT_LIMIT   = 200;    // cycles to collect one frame

    logic                sysclk;
    logic                arst_n;
    reg_wr_t             reg_wr;
    reg_addr_t           reg_raddr;
    logic [31:0]         reg_rdata;
    logic [NUM_CHAN-1:0] enc_a;
    logic [NUM_CHAN-1:0] enc_b;
    logic [NUM_CHAN-1:0] amp_fault;       // low is a fault
    logic [NUM_CHAN-1:0] amp_disable_pin;
    logic                dac_sclk;
    logic                dac_mosi;
    logic                dac_csel;

    // reference model state
    logic [NUM_CHAN-1:0][CMD_WIDTH-1:0] exp_cmd;
    logic [NUM_CHAN-1:0][ENC_WIDTH-1:0] exp_cnt;
    logic [NUM_CHAN-1:0][ENC_WIDTH-1:0] exp_pre;
    logic [NUM_CHAN-1:0][2:0]           exp_stat;   // fault_seen, safety, enable
    logic [NUM_CHAN-1:0][1:0]           enc_phase;  // quadrature position

    qla_board #(.SCLK_HALF(2)) i_qla_board (.*);

    always #HALF_PERIOD sysclk = ~sysclk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_with_failure("value check failed");
        end
    endtask

    // ------------------------------
    // register bus
    // ------------------------------
    task automatic reg_write(input logic [3:0] ch, input logic [3:0] off,
                             input logic [31:0] data, input logic blk);
        @(negedge sysclk);
        reg_wr.waddr   = '{space: ADDR_MAIN, unused: 4'd0, chan: ch, offset: off};
        reg_wr.wdata   = data;
        reg_wr.wen     = 1'b1;
        reg_wr.blk_wen = blk;
        @(negedge sysclk);
        reg_wr.wen     = 1'b0;
        reg_wr.blk_wen = 1'b0;
    endtask

    task automatic check_read(input logic [3:0] ch, input logic [3:0] off,
                              input logic [31:0] exp);
        @(negedge sysclk);
        reg_raddr = '{space: ADDR_MAIN, unused: 4'd0, chan: ch, offset: off};
        #2;                                         // read mux is combinational
        check_value($sformatf("ch %0d offset %0d", ch, off), reg_rdata, exp);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < NUM_CHAN; i++) begin
            check_read(4'(i + 1), OFF_MOTOR_CTRL, {29'd0, exp_stat[i]});
            check_read(4'(i + 1), OFF_DAC_CTRL, {16'd0, exp_cmd[i]});
            check_read(4'(i + 1), OFF_ENC_LOAD, {8'd0, exp_pre[i]});
            check_read(4'(i + 1), OFF_ENC_DATA, {8'd0, exp_cnt[i]});
        end
    endtask

    // ------------------------------
    // dac capture
    // ------------------------------
    task automatic wait_csel(input logic level, input string what);
        int n;
        n = 0;
        while (dac_csel !== level) begin
            if (n == CSEL_LIMIT) begin
                stop_with_failure({"timeout waiting for dac_csel to ", what});
            end else begin
                @(negedge sysclk);
                n++;
            end
        end
    endtask

    // bits are taken on rising sclk, polled at the sysclk falling edge
    task automatic grab_frame(output logic [DAC_FRAME_BITS-1:0] frame);
        int   n;
        int   bits;
        logic sclk_q;
        frame = '0;
        wait_csel(1'b0, "fall");
        n      = 0;
        bits   = 0;
        sclk_q = dac_sclk;
        while (bits < DAC_FRAME_BITS) begin
            if (n == BIT_LIMIT) begin
                stop_with_failure("timeout collecting a dac frame");
            end else begin
                @(negedge sysclk);
                n++;
                if (dac_sclk && !sclk_q) begin
                    frame = {frame[DAC_FRAME_BITS-2:0], dac_mosi};
                    bits++;
                end
                sclk_q = dac_sclk;
            end
        end
        wait_csel(1'b1, "rise");                    // frame closed
    endtask

    task automatic check_update(input logic [NUM_CHAN-1:0][CMD_WIDTH-1:0] cmds);
        logic [DAC_FRAME_BITS-1:0] frame;
        for (int i = 0; i < NUM_CHAN; i++) begin
            grab_frame(frame);
            check_value($sformatf("dac frame %0d", i), 32'(frame),
                        {8'd0, DAC_CMD_WRITE_UPDATE, 4'(i), cmds[i]});
        end
    endtask

    // one quadrature step, then at least four quiet cycles
    task automatic step_encoder(input int idx, input bit fwd);
        @(negedge sysclk);
        enc_phase[idx] = fwd ? enc_phase[idx] + 2'd1 : enc_phase[idx] - 2'd1;
        exp_cnt[idx]   = fwd ? exp_cnt[idx] + 24'd1 : exp_cnt[idx] - 24'd1;
        enc_a[idx]     = ^enc_phase[idx];           // 00 10 11 01 going forward
        enc_b[idx]     = enc_phase[idx][1];
        repeat (3) @(negedge sysclk);
    endtask

    // first failed bound assertion ends the run
    always @(negedge sysclk) begin
        if (i_qla_board.i_qla_board_asserts.fail_cnt != 0) begin
            stop_with_failure("a bound assertion on qla_board failed");
        end
    end

    initial begin
        logic [31:0]                        data;
        logic [NUM_CHAN-1:0][CMD_WIDTH-1:0] snap;
        void'($urandom(SEED));
        sysclk    = 1'b0;
        arst_n    = 1'b0;
        reg_wr    = '0;
        reg_raddr = '0;
        enc_a     = '0;
        enc_b     = '0;
        amp_fault = '1;
        exp_cmd   = '0;
        exp_cnt   = '0;
        exp_pre   = '0;
        exp_stat  = '0;
        enc_phase = '0;
        repeat (16) @(negedge sysclk);
        arst_n = 1'b1;

        // ------------------------------
        // reset state
        // ------------------------------
        @(negedge sysclk);
        #2;
        check_value("dac_csel after reset", 32'(dac_csel), 32'd1);
        check_value("amp_disable_pin after reset", 32'(amp_disable_pin), 32'hf);
        check_all_regs();

        // write and read back, preload also sets the count
        for (int i = 0; i < NUM_CHAN; i++) begin
            data       = $urandom;
            exp_cmd[i] = data[CMD_WIDTH-1:0];
            reg_write(4'(i + 1), OFF_DAC_CTRL, data, 1'b0);
            data       = $urandom;
            exp_pre[i] = data[ENC_WIDTH-1:0];
            exp_cnt[i] = data[ENC_WIDTH-1:0];
            reg_write(4'(i + 1), OFF_ENC_LOAD, data, 1'b0);
        end
        check_all_regs();
        reg_write(4'd0, OFF_DAC_CTRL, $urandom, 1'b0);    // ignored channels
        reg_write(4'd7, OFF_ENC_LOAD, $urandom, 1'b0);
        check_read(4'd7, OFF_DAC_CTRL, 32'd0);
        check_read(4'd0, OFF_ENC_DATA, 32'd0);
        check_all_regs();

        // ------------------------------
        // dac update, second request mid-round
        // ------------------------------
        data       = $urandom;
        exp_cmd[0] = data[CMD_WIDTH-1:0];
        reg_write(4'd1, OFF_DAC_CTRL, data, 1'b1);
        snap = exp_cmd;
        fork
            check_update(snap);
            begin
                repeat (40) @(negedge sysclk);
                data       = $urandom;
                exp_cmd[2] = data[CMD_WIDTH-1:0];
                reg_write(4'd3, OFF_DAC_CTRL, data, 1'b1);
            end
        join
        check_update(exp_cmd);

        // ------------------------------
        // encoders
        // ------------------------------
        for (int n = 0; n < 64; n++) begin
            step_encoder($urandom_range(NUM_CHAN - 1, 0), 1'($urandom_range(1, 0)));
        end
        repeat (4) @(negedge sysclk);
        check_all_regs();
        data       = $urandom;
        exp_pre[3] = data[ENC_WIDTH-1:0];
        exp_cnt[3] = data[ENC_WIDTH-1:0];
        reg_write(4'd4, OFF_ENC_LOAD, data, 1'b0);
        check_all_regs();

        // ------------------------------
        // amp enable and fault latch on channel 2
        // ------------------------------
        reg_write(4'd2, OFF_MOTOR_CTRL, 32'd1, 1'b0);
        exp_stat[1] = 3'b001;
        check_value("amp pin 2 enabled", 32'(amp_disable_pin[1]), 32'd0);
        @(negedge sysclk);
        amp_fault[1] = 1'b0;
        repeat (3) @(negedge sysclk);
        exp_stat[1] = 3'b111;                              // tripped and latched
        check_value("amp pin 2 tripped", 32'(amp_disable_pin[1]), 32'd1);
        check_read(4'd2, OFF_MOTOR_CTRL, {29'd0, exp_stat[1]});
        @(negedge sysclk);
        amp_fault[1] = 1'b1;
        repeat (3) @(negedge sysclk);
        reg_write(4'd2, OFF_MOTOR_CTRL, 32'd1, 1'b0);     // re-arm
        exp_stat[1] = 3'b001;
        check_value("amp pin 2 re-armed", 32'(amp_disable_pin[1]), 32'd0);
        reg_write(4'd2, OFF_MOTOR_CTRL, 32'd0, 1'b0);
        exp_stat[1] = 3'b000;
        @(negedge sysclk);
        amp_fault[1] = 1'b0;                               // fault while off
        repeat (3) @(negedge sysclk);
        check_value("amp pin 2 disabled", 32'(amp_disable_pin[1]), 32'd1);
        check_all_regs();
        amp_fault[1] = 1'b1;

        repeat (4) @(negedge sysclk);
        if (i_qla_board.i_qla_board_asserts.fail_cnt != 0) begin
            stop_with_failure("bound assertions reported errors");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
